/* Bender.yml */
package:
  name: usartTx

sources:
  - source/usartPkg.sv
  - source/usartCfgIf.sv
  - source/usartDataIf.sv
  - source/usartRegs.sv
  - source/usartBaudGen.sv
  - source/usartFrameTx.sv
  - source/usartTx.sv
  - target: test
    files:
      - testbench/usartTxClockGen.sv
      - testbench/usartTxTb.sv

/* source/usartBaudGen.sv */
`timescale 1ns/1ns
module usartBaudGen import usartPkg::*;
(
  input  logic      interf,
  input  logic      rstN,
  usartCfgIf.cfgSnk cfg,
  input  logic      ubrrWrite,
  output logic      bitTick
);

  baudCountT count;
  baudCountT reloadVal;
  logic      restartPend;

  // Bit period in clock cycles, minus one
  assign reloadVal = cfg.doubleSpeed
    ? baudCountT'((cfg.baudDiv + 1) * doubleOversample - 1)
    : baudCountT'((cfg.baudDiv + 1) * normalOversample - 1);

  always_ff @(posedge interf)
  begin
    if (!rstN)
    begin
      count       <= '0;
      restartPend <= 1'b0;
    end
    else
    begin
      restartPend <= ubrrWrite;  // New divisor is visible one cycle later
      if (ubrrWrite || restartPend || count == '0)
        count <= reloadVal;
      else
        count <= count - 1'b1;
    end
  end

  assign bitTick = (count == '0);

  tickIsSingle: assert property (@(posedge interf) disable iff (!rstN)
    bitTick |=> !bitTick);

endmodule

/* source/usartCfgIf.sv */
`timescale 1ns/1ns
interface usartCfgIf import usartPkg::*; ();

  charSizeT   charSize;
  parityModeT parityMode;
  logic       twoStop;
  logic       doubleSpeed;  // U2X
  baudDivT    baudDiv;
  logic       txEnable;

  modport cfgSrc (
    output charSize,
    output parityMode,
    output twoStop,
    output doubleSpeed,
    output baudDiv,
    output txEnable
  );

  // Each consumer picks the fields it needs
  modport cfgSnk (
    input charSize,
    input parityMode,
    input twoStop,
    input doubleSpeed,
    input baudDiv,
    input txEnable
  );

endinterface

/* source/usartDataIf.sv */
`timescale 1ns/1ns
interface usartDataIf import usartPkg::*; ();

  logic     valid;
  logic     ready;
  charDataT data;

  modport src (
    output valid,
    output data,
    input  ready
  );

  modport snk (
    input  valid,
    input  data,
    output ready
  );

endinterface

/* source/usartFrameTx.sv */
`timescale 1ns/1ns
module usartFrameTx import usartPkg::*;
(
  input  logic      interf,
  input  logic      rstN,
  usartCfgIf.cfgSnk cfg,
  usartDataIf.snk   rx,
  input  logic      bitTick,
  output logic      txd
);

  txStateT     state;
  logic [12:0] shiftReg;
  logic [12:0] frame;
  logic [3:0]  numData;
  logic [3:0]  frameLen;
  logic [3:0]  bitCnt;    // Frame bits still to send
  logic        parityBit;
  logic        xfer;
  logic        sendBit;

  assign rx.ready = (state == idle) && cfg.txEnable;
  assign xfer     = rx.valid && rx.ready;
  assign sendBit  = bitTick && ((state == load) || (state == shift && bitCnt != 4'd0));

  always_comb
  begin
    case (cfg.charSize)
      3'b000:  numData = 4'd5;
      3'b001:  numData = 4'd6;
      3'b010:  numData = 4'd7;
      3'b111:  numData = 4'd9;
      default: numData = 4'd8;  // Reserved codes act as 8 bits
    endcase
  end

  // Unused upper bits stay high so the stop bits come for free
  always_comb
  begin
    frame     = '1;
    frame[0]  = 1'b0;               // Start bit
    parityBit = cfg.parityMode[0];  // Odd parity
    for (int i = 0; i < 9; i++)
    begin
      if (i < numData)
      begin
        frame[i + 1] = rx.data[i];
        parityBit    = parityBit ^ rx.data[i];
      end
    end
    if (cfg.parityMode[1])
      frame[numData + 1] = parityBit;
  end

  assign frameLen = 4'd2 + numData + {3'b000, cfg.parityMode[1]} + {3'b000, cfg.twoStop};

  always_ff @(posedge interf)
  begin
    if (xfer)
      shiftReg <= frame;
    else if (sendBit)
      shiftReg <= {1'b1, shiftReg[12:1]};  // LSB goes out first
  end

  always_ff @(posedge interf)
  begin
    if (!rstN)
    begin
      state  <= idle;
      bitCnt <= '0;
      txd    <= 1'b1;
    end
    else
    begin
      case (state)
        idle:
          if (xfer)
          begin
            bitCnt <= frameLen;
            state  <= load;
          end
        load:
          if (bitTick)
            state <= shift;
        shift:
          if (bitTick && bitCnt == 4'd0)
            state <= done;  // Last stop bit has run its full period
        done:
          state <= idle;
        default:
          state <= idle;
      endcase

      if (sendBit)
      begin
        txd    <= shiftReg[0];
        bitCnt <= bitCnt - 4'd1;
      end
    end
  end

  lineIdleHigh: assert property (@(posedge interf) disable iff (!rstN)
    state == idle |-> txd);

  // Offered character stays valid until the transmitter takes it
  validHeld: assert property (@(posedge interf) disable iff (!rstN)
    rx.valid && !rx.ready |=> rx.valid);

endmodule

/* source/usartPkg.sv */
package usartPkg;

  typedef logic [7:0]  busDataT;
  typedef logic [8:0]  charDataT;   // Bit 8 is the ninth data bit
  typedef logic [11:0] baudDivT;
  typedef logic [15:0] baudCountT;  // Holds 16 x 4096 - 1
  typedef logic [2:0]  charSizeT;   // {UCSZ2, UCSZ1:0}
  typedef logic [1:0]  parityModeT; // 00 none, 10 even, 11 odd

  // Register map
  localparam busDataT addrUcsrA = 8'hC0;
  localparam busDataT addrUcsrB = 8'hC1;
  localparam busDataT addrUcsrC = 8'hC2;
  localparam busDataT addrUbrrL = 8'hC4;
  localparam busDataT addrUbrrH = 8'hC5;
  localparam busDataT addrUdr   = 8'hC6;

  localparam busDataT ucsrAReset = 8'h20; // UDRE set
  localparam busDataT ucsrBReset = 8'h00;
  localparam busDataT ucsrCReset = 8'h06; // 8-bit characters

  // Clock cycles per bit for each divisor step
  localparam int unsigned normalOversample = 16;
  localparam int unsigned doubleOversample = 8;

  typedef enum logic [1:0] {
    idle,
    load,
    shift,
    done
  } txStateT;

endpackage

/* source/usartRegs.sv */
`timescale 1ns/1ns
module usartRegs import usartPkg::*;
(
  input  logic      interf,
  input  logic      rstN,
  input  busDataT   addr,
  input  logic      wrEn,
  input  busDataT   wrData,
  input  logic      rdEn,
  output busDataT   rdData,
  output logic      ubrrWrite,
  usartCfgIf.cfgSrc cfg,
  usartDataIf.src   tx
);

  logic       udre;
  logic       u2x;
  logic       txEn;
  logic       ucsz2;
  logic       txb8;
  busDataT    ucsrC;
  busDataT    ubrrL;
  logic [3:0] ubrrH;
  busDataT    udrBuf;
  logic       dataWrite;

  assign dataWrite = wrEn && (addr == addrUdr);
  assign ubrrWrite = wrEn && ((addr == addrUbrrL) || (addr == addrUbrrH));

  always_ff @(posedge interf)
  begin
    if (!rstN)
    begin
      udre  <= ucsrAReset[5];
      u2x   <= ucsrAReset[1];
      txEn  <= ucsrBReset[3];
      ucsz2 <= ucsrBReset[2];
      txb8  <= ucsrBReset[0];
      ucsrC <= ucsrCReset;
      ubrrL <= '0;
      ubrrH <= '0;
    end
    else
    begin
      if (wrEn && addr == addrUcsrA)
        u2x <= wrData[1];  // UDRE is status only
      if (wrEn && addr == addrUcsrB)
      begin
        txEn  <= wrData[3];
        ucsz2 <= wrData[2];
        txb8  <= wrData[0];
      end
      if (wrEn && addr == addrUcsrC)
        ucsrC <= wrData;
      if (wrEn && addr == addrUbrrL)
        ubrrL <= wrData;
      if (wrEn && addr == addrUbrrH)
        ubrrH <= wrData[3:0];

      // Buffer full on write, empty again once the transmitter takes it
      if (dataWrite && udre)
        udre <= 1'b0;
      else if (tx.valid && tx.ready)
        udre <= 1'b1;
    end
  end

  // Writes to a full buffer are dropped
  always_ff @(posedge interf)
  begin
    if (dataWrite && udre)
      udrBuf <= wrData;
  end

  assign tx.valid = ~udre;
  assign tx.data  = {txb8, udrBuf};

  assign cfg.charSize    = {ucsz2, ucsrC[2:1]};
  assign cfg.parityMode  = ucsrC[5:4];
  assign cfg.twoStop     = ucsrC[3];
  assign cfg.doubleSpeed = u2x;
  assign cfg.baudDiv     = {ubrrH, ubrrL};
  assign cfg.txEnable    = txEn;

  always_comb
  begin
    rdData = '0;
    if (rdEn)
    begin
      case (addr)
        addrUcsrA: rdData = {2'b00, udre, 3'b000, u2x, 1'b0};
        addrUcsrB: rdData = {4'b0000, txEn, ucsz2, 1'b0, txb8};
        addrUcsrC: rdData = ucsrC;
        addrUbrrL: rdData = ubrrL;
        addrUbrrH: rdData = {4'b0000, ubrrH};
        default:   rdData = '0;  // UDR has no receive side
      endcase
    end
  end

  // A new character only appears after a data register write
  validNeedsWrite: assert property (@(posedge interf) disable iff (!rstN)
    $rose(tx.valid) |-> $past(dataWrite));

endmodule

/* source/usartTx.sv */
`timescale 1ns/1ns
module usartTx import usartPkg::*;
(
  input  logic    interf,
  input  logic    rstN,
  input  busDataT addr,
  input  logic    wrEn,
  input  busDataT wrData,
  input  logic    rdEn,
  output busDataT rdData,
  output logic    txd
);

  logic ubrrWrite;
  logic bitTick;

  usartCfgIf  cfgIf ();
  usartDataIf dataIf ();

  usartRegs uRegs (
    .interf    (interf),
    .rstN      (rstN),
    .addr      (addr),
    .wrEn      (wrEn),
    .wrData    (wrData),
    .rdEn      (rdEn),
    .rdData    (rdData),
    .ubrrWrite (ubrrWrite),
    .cfg       (cfgIf.cfgSrc),
    .tx        (dataIf.src)
  );

  usartBaudGen uBaudGen (
    .interf    (interf),
    .rstN      (rstN),
    .cfg       (cfgIf.cfgSnk),
    .ubrrWrite (ubrrWrite),
    .bitTick   (bitTick)
  );

  usartFrameTx uFrameTx (
    .interf  (interf),
    .rstN    (rstN),
    .cfg     (cfgIf.cfgSnk),
    .rx      (dataIf.snk),
    .bitTick (bitTick),
    .txd     (txd)
  );

endmodule

/* testbench/usartTxClockGen.sv */
`timescale 1ns/1ns
module usartTxClockGen
(
  output logic interf,
  output logic rstN
);

  initial
  begin
    interf = 1'b0;
    forever #5 interf = ~interf;  // 10 ns period
  end

  // Released on a falling edge, clear of the sampling edge
  initial
  begin
    rstN = 1'b0;
    repeat (10) @(posedge interf);
    @(negedge interf);
    rstN = 1'b1;
  end

endmodule

/* testbench/usartTxTb.sv */
`timescale 1ns/1ns
module usartTxTb import usartPkg::*; ();

  logic    interf, rstN, wrEn, rdEn, txd;
  busDataT addr, wrData, rdData;
  int      errors, checks;

  usartTxClockGen clkGen (.*);
  usartTx dut (.*);

  // Expected line bits, start bit first, stop bits left at the idle level
  function automatic void refFrame(input busDataT data, input int size, input int parity,
                                   input logic twoStop, input logic txb8,
                                   output logic [12:0] bits, output int len);
    charDataT ch;
    logic     par;
    ch      = {txb8, data};
    bits    = '1;
    bits[0] = 1'b0;
    par     = (parity == 3);  // Odd parity starts from one
    for (int i = 0; i < size; i++)
    begin
      bits[i + 1] = ch[i];
      par         = par ^ ch[i];
    end
    len = size + 1;
    if (parity >= 2)
    begin
      bits[len] = par;
      len++;
    end
    len = len + (twoStop ? 2 : 1);
  endfunction

  task automatic busWrite(input busDataT a, input busDataT d);
    @(negedge interf);
    addr   = a;
    wrData = d;
    wrEn   = 1'b1;
    @(negedge interf);
    wrEn   = 1'b0;
  endtask

  task automatic busRead(input busDataT a, output busDataT d);
    @(negedge interf);
    addr = a;
    rdEn = 1'b1;
    #2;
    d    = rdData;  // Mid low phase
    @(negedge interf);
    rdEn = 1'b0;
  endtask

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  task automatic setFormat(input int div, input logic u2x, input int size, input int parity,
                           input logic twoStop, input logic txb8);
    logic [2:0] code;
    code = (size == 9) ? 3'b111 : 3'(size - 5);  // {UCSZ2, UCSZ1:0}
    busWrite(addrUbrrH, busDataT'(div >> 8));
    busWrite(addrUbrrL, busDataT'(div));
    busWrite(addrUcsrA, {6'b000000, u2x, 1'b0});
    busWrite(addrUcsrC, {2'b00, 2'(parity), twoStop, code[1:0], 1'b0});
    busWrite(addrUcsrB, {4'b0000, 1'b1, code[2], 1'b0, txb8});  // TXEN on
  endtask

  // Samples the middle of each bit, timed from the falling start edge
  task automatic checkFrame(input string name, input logic [12:0] bits, input int len,
                            input int period, output int startLen);
    int n;
    n = 0;
    @(negedge interf);
    while (txd && n < 2 * period + 20)
    begin
      @(negedge interf);
      n++;
    end
    if (txd)
    begin
      errors++;
      $display("%s: no start bit appeared on txd before the timeout", name);
    end
    startLen = 0;
    for (int t = 0; t < len * period; t++)
    begin
      if (!txd && startLen == t)
        startLen++;  // Low cycles of the start bit
      if (t % period == period / 2)
        compare($sformatf("%s bit %0d", name, t / period), bits[t / period], txd);
      @(negedge interf);
    end
  endtask

  initial
  begin
    busDataT     rd, data;
    logic [12:0] bits;
    logic        twoStop, txb8;
    int          len, n, div, parity, startLen;
    addr   = '0;
    wrEn   = 1'b0;
    wrData = '0;
    rdEn   = 1'b0;
    errors = 0;
    checks = 0;
    void'($urandom(32'h8825_7e2a));
    repeat (12) @(negedge interf);

    busRead(addrUcsrA, rd);
    compare("reset UCSRA", 8'h20, rd);
    busRead(addrUcsrB, rd);
    compare("reset UCSRB", 8'h00, rd);
    busRead(addrUcsrC, rd);
    compare("reset UCSRC", 8'h06, rd);
    compare("reset txd", 1'b1, txd);

    data = busDataT'($urandom);
    busWrite(addrUbrrL, data);
    busRead(addrUbrrL, rd);
    compare("UBRRL readback", data, rd);
    data = busDataT'($urandom);
    busWrite(addrUbrrH, data);
    busRead(addrUbrrH, rd);
    compare("UBRRH readback", {4'h0, data[3:0]}, rd);  // Only the low nibble is kept
    data = busDataT'($urandom);
    busWrite(addrUcsrC, data);
    busRead(addrUcsrC, rd);
    compare("UCSRC readback", data, rd);

    // 8N1 at divisor 2
    setFormat(2, 1'b0, 8, 0, 1'b0, 1'b0);
    data = busDataT'($urandom);
    refFrame(data, 8, 0, 1'b0, 1'b0, bits, len);
    busWrite(addrUdr, data);
    checkFrame("8N1 frame", bits, len, 48, startLen);
    busRead(addrUcsrA, rd);
    compare("UDRE after frame", 1'b1, rd[5]);

    for (int k = 0; k < 15; k++)
    begin
      parity  = (k % 3 == 0) ? 0 : k % 3 + 1;  // None, even, odd
      twoStop = ((k / 5) % 2) == 1;
      txb8    = 1'($urandom);
      div     = $urandom % 4;
      data    = busDataT'($urandom);
      setFormat(div, 1'b0, 5 + k % 5, parity, twoStop, txb8);
      refFrame(data, 5 + k % 5, parity, twoStop, txb8, bits, len);
      busWrite(addrUdr, data);
      checkFrame($sformatf("format %0d", k), bits, len, (div + 1) * 16, startLen);
    end

    // Normal period at divisor 1 is 32 cycles
    setFormat(1, 1'b1, 8, 0, 1'b0, 1'b0);
    data = busDataT'($urandom) | 8'h01;
    refFrame(data, 8, 0, 1'b0, 1'b0, bits, len);
    busWrite(addrUdr, data);
    checkFrame("U2X frame", bits, len, 16, startLen);
    compare("U2X bit period", 32 / 2, startLen);

    // Buffer held full with the transmitter off
    setFormat(0, 1'b0, 8, 0, 1'b0, 1'b0);
    busWrite(addrUcsrB, 8'h00);
    data = busDataT'($urandom);
    busWrite(addrUdr, data);
    busWrite(addrUdr, ~data);
    busRead(addrUcsrA, rd);
    compare("UDRE while full", 1'b0, rd[5]);
    refFrame(data, 8, 0, 1'b0, 1'b0, bits, len);
    busWrite(addrUcsrB, 8'h08);
    fork
      checkFrame("held char", bits, len, 16, startLen);
      begin
        n  = 0;
        rd = '0;
        while (!rd[5] && n < 100)
        begin
          busRead(addrUcsrA, rd);
          n++;
        end
        if (!rd[5])
        begin
          errors++;
          $display("UDRE did not return to 1 before the timeout");
        end
      end
    join
    n = 0;
    repeat (2 * len * 16)
    begin
      @(negedge interf);
      if (!txd)
        n++;
    end
    compare("line idle after held char", 0, n);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

/* usartTx.f */
source/usartPkg.sv
source/usartCfgIf.sv
source/usartDataIf.sv
source/usartRegs.sv
source/usartBaudGen.sv
source/usartFrameTx.sv
source/usartTx.sv
testbench/usartTxClockGen.sv
testbench/usartTxTb.sv
